//--- logic/uart_macros.svh
// UART frame constants for the data width and the total frame length
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Payload bits carried in one frame
`define UART_DATA_BITS 8

// Start bit, data bits, parity bit and stop bit together
`define UART_FRAME_BITS 11

// Frame layout by bit index
//   0       start bit, always 0
//   1 to 8  data, least significant bit first
//   9       parity, even or odd by configuration
//   10      stop bit, always 1
// The line idles high between frames

`endif

//--- logic/uart_pkg.sv
// UART link package with the width typedefs and the FSM state encodings
`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

    // Byte moved by either path
    typedef logic [`UART_DATA_BITS-1:0] uart_data_t;

    // Whole frame word, bit 0 leaves the line first
    typedef logic [`UART_FRAME_BITS-1:0] frame_t;

    // Bit position inside a frame, 0 to 10
    typedef logic [3:0] bit_count_t;

    // Transmit FSM
    typedef enum logic {
        TX_IDLE = 1'b0, // Line idle, waiting for start
        TX_SEND = 1'b1  // Frame on the line
    } tx_state_t;

    // Receive FSM
    typedef enum logic [1:0] {
        RX_IDLE    = 2'd0, // Hunting for a start bit
        RX_COLLECT = 2'd1, // Sampling data, parity, stop
        RX_DONE    = 2'd2  // Results out for one cycle
    } rx_state_t;

endpackage

`default_nettype wire

//--- logic/bit_counter.sv
// Bit position counter for one frame with a flag on the last position
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module bit_counter (
    input  logic               baud_clk,
    input  logic               rst,
    input  logic               clear,   // Restart at position 0
    input  logic               enable,  // Step to the next position
    output uart_pkg::bit_count_t count,
    output logic               last     // Stop bit position reached
);

    import uart_pkg::*;

    // Index of the stop bit
    localparam bit_count_t LAST_POS = bit_count_t'(`UART_FRAME_BITS - 1);

    bit_count_t count_q;

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;              // Clear wins over enable
        end else if (enable) begin
            count_q <= count_q + 1'b1;  // One position per baud_clk
        end
    end

    assign count = count_q;
    assign last  = (count_q == LAST_POS); // Decoded from the register

endmodule

`default_nettype wire

//--- logic/tx_ctrl_fsm.sv
// Transmit FSM that raises busy and steers the frame shifter and bit counter
`default_nettype none
`timescale 1ns/1ps

module tx_ctrl_fsm (
    input  logic baud_clk,
    input  logic rst,
    input  logic start,       // Single cycle request from outside
    output logic busy,        // High for the whole frame
    output logic load,        // Build frame in the shifter
    output logic shift,       // Advance tx by one bit
    output logic cnt_clear,   // Restart the bit counter
    output logic cnt_enable,  // Count one bit
    input  logic cnt_last     // Stop bit on the line
);

    import uart_pkg::*;

    tx_state_t state_q;
    tx_state_t state_d;
    logic      accept;

    // Start only counts while idle
    assign accept = (state_q == TX_IDLE) && start;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            TX_IDLE: begin
                if (start) begin
                    state_d = TX_SEND;    // Frame goes out next cycle
                end
            end
            TX_SEND: begin
                if (cnt_last) begin
                    state_d = TX_IDLE;    // Stop bit done
                end
            end
            default: begin
                state_d = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            state_q <= TX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy       = (state_q == TX_SEND); // Registered, 11 cycles wide
    assign load       = accept;               // Frame register fills on edge E
    assign cnt_clear  = accept;               // Position 0 is the start bit
    assign shift      = busy;                 // Last shift leaves all ones
    assign cnt_enable = busy;

endmodule

`default_nettype wire

//--- logic/tx_frame_shifter.sv
// Transmit shifter that frames the byte with parity and drives it onto tx
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module tx_frame_shifter (
    input  logic               baud_clk,
    input  logic               rst,
    input  uart_pkg::uart_data_t data,       // Byte sampled on load
    input  logic               parity_odd,   // 0 even, 1 odd
    input  logic               load,         // Capture a new frame
    input  logic               shift,        // Next bit onto the line
    output logic               tx
);

    import uart_pkg::*;

    frame_t frame_q;
    frame_t frame_new;
    logic   parity_bit;

    // Even parity is the plain XOR of the byte
    assign parity_bit = (^data) ^ parity_odd;

    // Stop, parity, data, start from MSB down to LSB
    assign frame_new = {1'b1, parity_bit, data, 1'b0};

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            frame_q <= '1;                    // Line idles high
        end else if (load) begin
            frame_q <= frame_new;             // Start bit lands on tx
        end else if (shift) begin
            // Ones fill in from the top
            frame_q <= {1'b1, frame_q[`UART_FRAME_BITS-1:1]};
        end
    end

    // Straight from a flop so tx has no glitches
    assign tx = frame_q[0];

endmodule

`default_nettype wire

//--- logic/rx_ctrl_fsm.sv
// Receive FSM for start detection, bit collection and the valid strobe
`default_nettype none
`timescale 1ns/1ps

module rx_ctrl_fsm (
    input  logic baud_clk,
    input  logic rst,
    input  logic rx_bit,      // Synchronized line sample
    output logic shift,       // Take rx_bit into the checker
    output logic capture,     // Latch byte and error flags
    output logic cnt_clear,   // Start bit seen
    output logic cnt_enable,  // Count one collected bit
    input  logic cnt_last,    // Stop bit already sampled
    output logic valid        // One cycle result strobe
);

    import uart_pkg::*;

    rx_state_t state_q;
    rx_state_t state_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RX_IDLE: begin
                if (!rx_bit) begin
                    state_d = RX_COLLECT;  // Falling line means start bit
                end
            end
            RX_COLLECT: begin
                if (cnt_last) begin
                    state_d = RX_DONE;     // Data, parity and stop are in
                end
            end
            RX_DONE: begin
                state_d = RX_IDLE;         // Single result cycle
            end
            default: begin
                state_d = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            state_q <= RX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counter sits at 0 on the start bit edge
    assign cnt_clear  = (state_q == RX_IDLE) && !rx_bit;
    assign cnt_enable = (state_q == RX_COLLECT);
    assign shift      = (state_q == RX_COLLECT); // Last shift is ignored

    // Latch on the edge into RX_DONE
    // Results and valid then share the same cycle
    assign capture = (state_q == RX_COLLECT) && cnt_last;
    assign valid   = (state_q == RX_DONE);

endmodule

`default_nettype wire

//--- logic/rx_frame_checker.sv
// Receive shifter that collects a frame and checks its parity and stop bit
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module rx_frame_checker (
    input  logic               baud_clk,
    input  logic               rst,
    input  logic               rx_bit,         // Synchronized line sample
    input  logic               parity_odd,     // 0 even, 1 odd
    input  logic               shift,          // Sample rx_bit this cycle
    input  logic               capture,        // Latch checked results
    output uart_pkg::uart_data_t data,
    output logic               parity_error,   // Parity bit disagrees
    output logic               framing_error   // Stop bit sampled low
);

    import uart_pkg::*;

    // Data, parity and stop without the start bit
    localparam int COLLECT_BITS = `UART_FRAME_BITS - 1;

    logic [COLLECT_BITS-1:0] shift_q;
    uart_data_t              data_q;
    uart_data_t              rx_byte;
    logic                    rx_parity;
    logic                    rx_stop;
    logic                    parity_bad;

    // New bit enters at the top, first data bit ends at 0
    always_ff @(posedge baud_clk) begin
        if (shift) begin
            shift_q <= {rx_bit, shift_q[COLLECT_BITS-1:1]};
        end
    end

    assign rx_byte   = shift_q[`UART_DATA_BITS-1:0];
    assign rx_parity = shift_q[`UART_DATA_BITS];
    assign rx_stop   = shift_q[COLLECT_BITS-1];

    // Expected parity is XOR of the byte, flipped for odd
    assign parity_bad = rx_parity ^ (^rx_byte) ^ parity_odd;

    always_ff @(posedge baud_clk) begin
        if (capture) begin
            data_q <= rx_byte;             // Held until the next frame
        end
    end

    always_ff @(posedge baud_clk) begin
        if (rst) begin
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end else if (capture) begin
            parity_error  <= parity_bad;
            framing_error <= !rx_stop;     // Stop must be high
        end
    end

    assign data = data_q;

endmodule

`default_nettype wire

//--- logic/uart_link.sv
// UART link top joining the transmit and receive paths on one baud clock
`default_nettype none
`timescale 1ns/1ps

module uart_link (
    input  logic               baud_clk,
    input  logic               rst,
    input  logic               parity_odd,        // Shared by both paths
    input  uart_pkg::uart_data_t tx_data,
    input  logic               tx_start,          // One cycle strobe
    output logic               tx,
    output logic               tx_busy,
    input  logic               rx,                // Asynchronous line
    output uart_pkg::uart_data_t rx_data,
    output logic               rx_valid,
    output logic               rx_parity_error,
    output logic               rx_framing_error
);

    import uart_pkg::*;

    logic tx_load;
    logic tx_shift;
    logic tx_cnt_clear;
    logic tx_cnt_enable;
    logic tx_cnt_last;
    logic rx_meta;
    logic rx_bit;
    logic rx_shift;
    logic rx_capture;
    logic rx_cnt_clear;
    logic rx_cnt_enable;
    logic rx_cnt_last;

    // Two flop synchronizer, reset high so no false start
    always_ff @(posedge baud_clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_bit  <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_bit  <= rx_meta;
        end
    end

    tx_ctrl_fsm u_tx_ctrl (.baud_clk, .rst, .start(tx_start), .busy(tx_busy),
        .load(tx_load), .shift(tx_shift), .cnt_clear(tx_cnt_clear),
        .cnt_enable(tx_cnt_enable), .cnt_last(tx_cnt_last));

    bit_counter u_tx_count (.baud_clk, .rst, .clear(tx_cnt_clear),
        .enable(tx_cnt_enable), .count(), .last(tx_cnt_last)); // Only last used

    tx_frame_shifter u_tx_shift (.baud_clk, .rst, .data(tx_data), .parity_odd,
        .load(tx_load), .shift(tx_shift), .tx);

    rx_ctrl_fsm u_rx_ctrl (.baud_clk, .rst, .rx_bit, .shift(rx_shift),
        .capture(rx_capture), .cnt_clear(rx_cnt_clear), .cnt_enable(rx_cnt_enable),
        .cnt_last(rx_cnt_last), .valid(rx_valid));

    bit_counter u_rx_count (.baud_clk, .rst, .clear(rx_cnt_clear),
        .enable(rx_cnt_enable), .count(), .last(rx_cnt_last));

    rx_frame_checker u_rx_check (.baud_clk, .rst, .rx_bit, .parity_odd,
        .shift(rx_shift), .capture(rx_capture), .data(rx_data),
        .parity_error(rx_parity_error), .framing_error(rx_framing_error));

endmodule

`default_nettype wire

//--- bench/uart_link_assertions.sv
// Bound checks on the transmit handshake, the idle tx line and the receive strobe
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_link_assertions (
    input logic baud_clk,
    input logic rst,
    input logic tx_start,
    input logic tx_busy,
    input logic tx,
    input logic rx_valid
);

    int fail_count = 0;  // Failed assertions so far

    // Accepted start gives a busy window of exactly one frame
    busy_window: assert property (@(posedge baud_clk) disable iff (rst)
        tx_start && !tx_busy |=> tx_busy [*`UART_FRAME_BITS] ##1 !tx_busy)
    else begin
        fail_count++;
        $error("tx_busy window is not %0d cycles after an accepted start", `UART_FRAME_BITS);
    end

    // Line must idle high between frames
    tx_idle_high: assert property (@(posedge baud_clk) disable iff (rst)
        !tx_busy |-> tx)
    else begin
        fail_count++;
        $error("tx is low while tx_busy is low");
    end

    rx_valid_single: assert property (@(posedge baud_clk) disable iff (rst)
        rx_valid |=> !rx_valid)
    else begin
        fail_count++;
        $error("rx_valid held high for two cycles in a row");
    end

endmodule

bind uart_link uart_link_assertions u_assert (.baud_clk, .rst, .tx_start, .tx_busy, .tx,
    .rx_valid);

`default_nettype wire

//--- bench/uart_link_tb.sv
// Table driven testbench for the UART link with loopback, injected frames and busy starts
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_link_tb;

    localparam int NUM_ROWS     = 11;
    localparam int RESET_CYCLES = 10;
    localparam int ROW_BUDGET   = 30;   // Cycles allowed per table row
    localparam int MODE_LOOP    = 0;    // rx wired to tx
    localparam int MODE_PARITY  = 1;    // Injected frame with parity flipped
    localparam int MODE_STOP    = 2;    // Injected frame with stop at 0
    localparam int MODE_BUSY    = 3;    // Second start while busy

    logic        baud_clk = 1'b0;
    logic        rst;
    logic        parity_odd;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx;
    logic        tx_busy;
    logic        rx_line;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_parity_error;
    logic        rx_framing_error;
    logic        use_injector;        // Mux select for rx
    logic        inj_bit;             // Injector line level
    int          check_count = 0;
    int          error_count = 0;
    int          valid_count = 0;     // rx_valid strobes seen so far
    integer      seed = 32'ha769_32a2;
    logic [31:0] rand_word;
    int          row_idx;

    // Stimulus table with one entry per test
    string       row_name [NUM_ROWS];
    logic [7:0]  row_data [NUM_ROWS];
    logic        row_odd  [NUM_ROWS];
    int          row_mode [NUM_ROWS];
    logic        row_perr [NUM_ROWS];  // Expected rx_parity_error
    logic        row_ferr [NUM_ROWS];  // Expected rx_framing_error

    always #50 baud_clk = ~baud_clk;   // 100 ns period

    assign rx_line = use_injector ? inj_bit : tx;

    uart_link DUT (.baud_clk, .rst, .parity_odd, .tx_data, .tx_start, .tx, .tx_busy,
        .rx(rx_line), .rx_data, .rx_valid, .rx_parity_error, .rx_framing_error);

    always @(negedge baud_clk) begin
        if (!rst && rx_valid === 1'b1) begin
            valid_count <= valid_count + 1;
        end
    end

    // Start 0, data LSB first, parity, stop 1
    function automatic logic [`UART_FRAME_BITS-1:0] build_frame(input logic [7:0] data,
            input logic odd, input logic flip_parity, input logic stop_low);
        int   ones;
        logic parity;
        ones = 0;
        for (int b = 0; b < 8; b++) begin
            ones = ones + data[b];
        end
        parity = ones[0] ^ odd ^ flip_parity;  // Odd count of ones sets even parity
        return {~stop_low, parity, data, 1'b0};
    endfunction

    task automatic set_row(input int idx, input string name, input logic [7:0] data,
            input logic odd, input int mode, input logic perr, input logic ferr);
        row_name[idx] = name;
        row_data[idx] = data;
        row_odd[idx]  = odd;
        row_mode[idx] = mode;
        row_perr[idx] = perr;
        row_ferr[idx] = ferr;
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
        end
    endtask

    // Bit i goes on the line after edge i as in the DUT transmitter
    task automatic inject_frame(input logic [`UART_FRAME_BITS-1:0] frame);
        for (int b = 0; b < `UART_FRAME_BITS; b++) begin
            inj_bit <= frame[b];
            @(posedge baud_clk);
        end
        inj_bit <= 1'b1;                   // Back to idle
    endtask

    // Samples tx mid cycle once per bit and counts busy cycles
    task automatic decode_tx_frame(output logic [`UART_FRAME_BITS-1:0] frame,
            output int busy_cycles);
        busy_cycles = 0;
        for (int b = 0; b < `UART_FRAME_BITS; b++) begin
            @(negedge baud_clk);
            frame[b] = tx;
            if (tx_busy === 1'b1) begin
                busy_cycles++;
            end
        end
        @(negedge baud_clk);
        if (tx_busy === 1'b1) begin
            busy_cycles++;                 // Busy one cycle too long
        end
    endtask

    task automatic wait_rx_valid(output logic [7:0] data, output logic perr,
            output logic ferr);
        do begin
            @(negedge baud_clk);
        end while (rx_valid !== 1'b1);     // Result strobe seen mid cycle
        data = rx_data;
        perr = rx_parity_error;
        ferr = rx_framing_error;
    endtask

    task automatic run_row(input int idx);
        logic [`UART_FRAME_BITS-1:0] got_frame;
        logic [7:0]                  got_data;
        logic                        got_perr;
        logic                        got_ferr;
        logic                        injected;
        int                          busy_cycles;
        int                          valid_before;
        injected     = (row_mode[idx] == MODE_PARITY) || (row_mode[idx] == MODE_STOP);
        valid_before = valid_count;
        @(posedge baud_clk);
        parity_odd   <= row_odd[idx];      // Static while the frame runs
        use_injector <= injected;
        @(posedge baud_clk);
        if (injected) begin
            inject_frame(build_frame(row_data[idx], row_odd[idx],
                row_mode[idx] == MODE_PARITY, row_mode[idx] == MODE_STOP));
        end else begin
            tx_data  <= row_data[idx];
            tx_start <= 1'b1;
            @(posedge baud_clk);           // Edge where the start is taken
            tx_start <= 1'b0;
            fork
                decode_tx_frame(got_frame, busy_cycles);
                if (row_mode[idx] == MODE_BUSY) begin
                    repeat (4) @(posedge baud_clk);
                    tx_data  <= ~row_data[idx];  // Must not reach the line
                    tx_start <= 1'b1;
                    @(posedge baud_clk);
                    tx_start <= 1'b0;
                end
            join
            check_equal({row_name[idx], " tx frame"},
                build_frame(row_data[idx], row_odd[idx], 1'b0, 1'b0), got_frame);
            check_equal({row_name[idx], " busy cycles"}, `UART_FRAME_BITS, busy_cycles);
        end
        wait_rx_valid(got_data, got_perr, got_ferr);
        check_equal({row_name[idx], " rx_data"}, row_data[idx], got_data);
        check_equal({row_name[idx], " parity error"}, row_perr[idx], got_perr);
        check_equal({row_name[idx], " framing error"}, row_ferr[idx], got_ferr);
        repeat (8) @(posedge baud_clk);    // Room for a stray second strobe
        check_equal({row_name[idx], " rx_valid count"}, 1, valid_count - valid_before);
    endtask

    initial begin
        rst          = 1'b1;
        parity_odd   = 1'b0;
        tx_data      = '0;
        tx_start     = 1'b0;
        use_injector = 1'b0;
        inj_bit      = 1'b1;
        set_row(0, "loop_even_a5", 8'hA5, 1'b0, MODE_LOOP, 1'b0, 1'b0);
        set_row(1, "loop_odd_a5", 8'hA5, 1'b1, MODE_LOOP, 1'b0, 1'b0);
        set_row(2, "loop_even_00", 8'h00, 1'b0, MODE_LOOP, 1'b0, 1'b0);
        set_row(3, "loop_odd_ff", 8'hFF, 1'b1, MODE_LOOP, 1'b0, 1'b0);
        set_row(4, "inj_parity_even_3c", 8'h3C, 1'b0, MODE_PARITY, 1'b1, 1'b0);
        set_row(5, "inj_parity_odd_81", 8'h81, 1'b1, MODE_PARITY, 1'b1, 1'b0);
        set_row(6, "inj_stop_5a", 8'h5A, 1'b0, MODE_STOP, 1'b0, 1'b1);
        set_row(7, "busy_start_c3", 8'hC3, 1'b1, MODE_BUSY, 1'b0, 1'b0);
        for (row_idx = 8; row_idx < NUM_ROWS; row_idx++) begin
            rand_word = $random(seed);
            set_row(row_idx, $sformatf("loop_rand_%0d", row_idx), rand_word[7:0],
                rand_word[8], MODE_LOOP, 1'b0, 1'b0);
        end
        repeat (RESET_CYCLES) @(posedge baud_clk);
        rst <= 1'b0;
        @(negedge baud_clk);
        check_equal("reset tx", 1'b1, tx);
        check_equal("reset tx_busy", 1'b0, tx_busy);
        check_equal("reset rx_valid", 1'b0, rx_valid);
        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            run_row(row_idx);
        end
        error_count = error_count + DUT.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
            check_count, error_count, DUT.u_assert.fail_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * ROW_BUDGET) @(posedge baud_clk);
        error_count = error_count + 1;
        $display("Timeout: no rx_valid arrived before the watchdog limit");
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/uart_pkg.sv
logic/bit_counter.sv
logic/tx_ctrl_fsm.sv
logic/tx_frame_shifter.sv
logic/rx_ctrl_fsm.sv
logic/rx_frame_checker.sv
logic/uart_link.sv
bench/uart_link_assertions.sv
bench/uart_link_tb.sv

//--- Bender.yml
package:
  name: uart_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_pkg.sv
      - logic/bit_counter.sv
      - logic/tx_ctrl_fsm.sv
      - logic/tx_frame_shifter.sv
      - logic/rx_ctrl_fsm.sv
      - logic/rx_frame_checker.sv
      - logic/uart_link.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/uart_link_assertions.sv
      - bench/uart_link_tb.sv
